// ==== Makefile ====
# Verilator build and run for the TinyRV1 issue slice testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_checker.sv ====
/*
  Watches the DUT ports, runs the in-order reference model on each accepted
  instruction and compares every output transfer with the oldest expected result.
*/

`timescale 1ns/1ps

module tb_checker import tinyrv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      in_val,
  input  logic      in_rdy,
  input  word_t     in_inst,
  input  word_t     in_pc,
  input  seq_num_t  in_seq_num,
  input  logic      out_val,
  input  logic      out_rdy,
  input  word_t     out_pc,
  input  seq_num_t  out_seq_num,
  input  reg_addr_t out_waddr,
  input  logic      out_wen,
  input  word_t     out_wdata,
  output int        error_count,
  output int        outstanding,
  output int        in_count,
  output int        out_count
);

  // Architectural state, in program order
  word_t     arch_regs [32];
  logic      reset_checked;
  seq_num_t  exp_seq [$];
  word_t     exp_pc [$];
  logic      exp_wen [$];
  reg_addr_t exp_waddr [$];
  word_t     exp_wdata [$];
  string     exp_name [$];

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------

  // Returns {wen, wdata}
  function automatic logic [32:0] ref_exec(input word_t inst, input word_t src1,
                                           input word_t src2);
    logic [63:0] product;
    word_t       imm;
    word_t       value;
    logic        writes;
    imm     = {{20{inst[31]}}, inst[31:20]};
    product = {32'b0, src1} * {32'b0, src2};
    value   = '0;
    writes  = 1'b0;
    if (inst[6:0] == 7'b0010011 && inst[14:12] == 3'b000) begin
      value  = src1 + imm;
      writes = 1'b1;
    end else if (inst[6:0] == 7'b0110011 && inst[14:12] == 3'b000) begin
      if (inst[31:25] == 7'b0000000) begin
        value  = src1 + src2;
        writes = 1'b1;
      end else if (inst[31:25] == 7'b0000001) begin
        // Low word only, same for signed and unsigned
        value  = product[31:0];
        writes = 1'b1;
      end
    end
    if (inst[11:7] == 5'd0) begin
      writes = 1'b0;
    end
    return {writes, value};
  endfunction

  function automatic string test_name(input word_t inst, input seq_num_t seq);
    string kind;
    kind = "unsupported";
    if (inst[6:0] == 7'b0010011 && inst[14:12] == 3'b000) begin
      kind = "addi";
    end else if (inst[6:0] == 7'b0110011 && inst[14:12] == 3'b000) begin
      if (inst[31:25] == 7'b0000000) kind = "add";
      if (inst[31:25] == 7'b0000001) kind = "mul";
    end
    if (kind != "unsupported" && inst[11:7] == 5'd0) begin
      kind = "x0_write";
    end
    return $sformatf("%s#%0d", kind, seq);
  endfunction

  // ------------------------------------------------------------
  // Compare helpers
  // ------------------------------------------------------------

  task automatic check_value(input string test, input string field, input word_t expected,
                             input word_t actual);
    if (expected !== actual) begin
      $display("FAIL %s %s: expected 0x%08h actual 0x%08h", test, field, expected, actual);
      error_count++;
    end
  endtask

  task automatic accept_instruction();
    logic [32:0] res;
    reg_addr_t   rd;
    rd  = in_inst[11:7];
    res = ref_exec(in_inst, arch_regs[in_inst[19:15]], arch_regs[in_inst[24:20]]);
    if (res[32]) begin
      arch_regs[rd] = res[31:0];
    end
    exp_seq.push_back(in_seq_num);
    exp_pc.push_back(in_pc);
    exp_wen.push_back(res[32]);
    exp_waddr.push_back(rd);
    exp_wdata.push_back(res[31:0]);
    exp_name.push_back(test_name(in_inst, in_seq_num));
    in_count++;
  endtask

  task automatic compare_output();
    string name;
    logic  wen;
    if (exp_seq.size() == 0) begin
      $display("Result with seq %0d left the DUT with no instruction outstanding",
               out_seq_num);
      error_count++;
    end else begin
      name = exp_name.pop_front();
      wen  = exp_wen.pop_front();
      check_value(name, "seq_num", {24'b0, exp_seq.pop_front()}, {24'b0, out_seq_num});
      check_value(name, "pc", exp_pc.pop_front(), out_pc);
      check_value(name, "wen", {31'b0, wen}, {31'b0, out_wen});
      // Address and data only matter for a write
      if (wen) begin
        check_value(name, "waddr", {27'b0, exp_waddr[0]}, {27'b0, out_waddr});
        check_value(name, "wdata", exp_wdata[0], out_wdata);
      end
      void'(exp_waddr.pop_front());
      void'(exp_wdata.pop_front());
    end
    out_count++;
  endtask

  // ------------------------------------------------------------
  // Sampling, mid-cycle where the ports are stable
  // ------------------------------------------------------------

  always @(negedge clk) begin
    if (rst) begin
      error_count   = 0;
      in_count      = 0;
      out_count     = 0;
      reset_checked = 1'b0;
      for (int i = 0; i < 32; i++) begin
        arch_regs[i] = '0;
      end
      exp_seq.delete();
      exp_pc.delete();
      exp_wen.delete();
      exp_waddr.delete();
      exp_wdata.delete();
      exp_name.delete();
    end else begin
      // First cycle out of reset, nothing sent yet
      if (!reset_checked) begin
        check_value("reset", "in_rdy", 32'd1, {31'b0, in_rdy});
        check_value("reset", "out_val", 32'd0, {31'b0, out_val});
        reset_checked = 1'b1;
      end
      if (in_val && in_rdy) begin
        accept_instruction();
      end
      if (out_val && out_rdy) begin
        compare_output();
      end
    end
    outstanding = exp_seq.size();
  end

endmodule

// ==== dv/tb_top.sv ====
/*
  Testbench top for the TinyRV1 issue slice. Sends a directed program and an
  LFSR instruction stream with random valid and back-pressure; tb_checker compares.
*/

`timescale 1ns/1ps

module tb_top import tinyrv_pkg::*; ();

  // Directed part plus random fill
  localparam int num_total   = 180;
  localparam int cycle_limit = 20 * num_total + 100;

  logic      clk;
  logic      rst;
  logic      in_val;
  logic      in_rdy;
  word_t     in_inst;
  word_t     in_pc;
  seq_num_t  in_seq_num;
  logic      out_val;
  logic      out_rdy;
  word_t     out_pc;
  seq_num_t  out_seq_num;
  reg_addr_t out_waddr;
  logic      out_wen;
  word_t     out_wdata;

  int          error_count;
  int          outstanding;
  int          in_count;
  int          out_count;
  int          tb_errors;
  int          cycle_count;
  int          idx;
  logic        hold;
  logic [31:0] lfsr_state;
  word_t       prog [$];

  tinyrv_issue_top i_dut (
    .clk         (clk),
    .rst         (rst),
    .in_val      (in_val),
    .in_rdy      (in_rdy),
    .in_inst     (in_inst),
    .in_pc       (in_pc),
    .in_seq_num  (in_seq_num),
    .out_val     (out_val),
    .out_rdy     (out_rdy),
    .out_pc      (out_pc),
    .out_seq_num (out_seq_num),
    .out_waddr   (out_waddr),
    .out_wen     (out_wen),
    .out_wdata   (out_wdata)
  );

  tb_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .in_val      (in_val),
    .in_rdy      (in_rdy),
    .in_inst     (in_inst),
    .in_pc       (in_pc),
    .in_seq_num  (in_seq_num),
    .out_val     (out_val),
    .out_rdy     (out_rdy),
    .out_pc      (out_pc),
    .out_seq_num (out_seq_num),
    .out_waddr   (out_waddr),
    .out_wen     (out_wen),
    .out_wdata   (out_wdata),
    .error_count (error_count),
    .outstanding (outstanding),
    .in_count    (in_count),
    .out_count   (out_count)
  );

  // ------------------------------------------------------------
  // Random source and instruction encoding
  // ------------------------------------------------------------

  // Galois LFSR, one step per bit taken, taps 32,22,2,1
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    logic        bit_out;
    val = '0;
    for (int i = 0; i < n; i++) begin
      bit_out    = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (bit_out) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
      end
      val = {val[30:0], bit_out};
    end
    return val;
  endfunction

  // add when funct7 is zero, mul when it is one
  function automatic word_t r_type_word(input logic [6:0] funct7, input reg_addr_t rs2,
                                        input reg_addr_t rs1, input reg_addr_t rd);
    return {funct7, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  // addi
  function automatic word_t i_type_word(input logic [11:0] imm, input reg_addr_t rs1,
                                        input reg_addr_t rd);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  // Registers x0..x7 only, so hazards come often
  function automatic word_t random_inst();
    logic [31:0] r;
    logic [2:0]  kind;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [11:0] imm;
    word_t       inst;
    r    = lfsr_bits(3);
    kind = r[2:0];
    r    = lfsr_bits(9);
    rd   = {2'b00, r[2:0]};
    rs1  = {2'b00, r[5:3]};
    rs2  = {2'b00, r[8:6]};
    r    = lfsr_bits(12);
    imm  = r[11:0];
    case (kind)
      3'd0, 3'd1, 3'd2: inst = i_type_word(imm, rs1, rd);
      3'd3, 3'd4:       inst = r_type_word(7'b0000000, rs2, rs1, rd);
      3'd5, 3'd6:       inst = r_type_word(7'b0000001, rs2, rs1, rd);
      default: begin
        // Branch opcode, not supported
        r    = lfsr_bits(25);
        inst = {r[24:0], 7'b1100011};
      end
    endcase
    return inst;
  endfunction

  task automatic build_program();
    // Independent immediates and adds
    prog.push_back(i_type_word(12'd100, 5'd0, 5'd1));
    prog.push_back(i_type_word(12'hFDB, 5'd0, 5'd2));   // -37
    prog.push_back(i_type_word(12'd2047, 5'd0, 5'd3));
    prog.push_back(i_type_word(12'h800, 5'd0, 5'd4));   // -2048
    prog.push_back(r_type_word(7'b0000000, 5'd3, 5'd1, 5'd5));
    prog.push_back(r_type_word(7'b0000000, 5'd4, 5'd2, 5'd6));
    // mul with negative operands
    prog.push_back(r_type_word(7'b0000001, 5'd3, 5'd2, 5'd5));
    prog.push_back(r_type_word(7'b0000001, 5'd4, 5'd2, 5'd6));
    prog.push_back(r_type_word(7'b0000001, 5'd4, 5'd4, 5'd7));
    // RAW then WAW chain on x1
    prog.push_back(i_type_word(12'd1, 5'd1, 5'd1));
    prog.push_back(r_type_word(7'b0000000, 5'd1, 5'd1, 5'd1));
    prog.push_back(r_type_word(7'b0000001, 5'd2, 5'd1, 5'd1));
    prog.push_back(i_type_word(12'hFFB, 5'd1, 5'd1));   // -5
    prog.push_back(r_type_word(7'b0000000, 5'd1, 5'd1, 5'd1));
    prog.push_back(i_type_word(12'd7, 5'd0, 5'd1));
    // Writes to x0, then reads of it
    prog.push_back(i_type_word(12'd55, 5'd1, 5'd0));
    prog.push_back(r_type_word(7'b0000001, 5'd2, 5'd2, 5'd0));
    prog.push_back(r_type_word(7'b0000000, 5'd0, 5'd0, 5'd7));
    // sub, bne and lw encodings pass through as nops
    prog.push_back(r_type_word(7'b0100000, 5'd2, 5'd1, 5'd3));
    prog.push_back({7'd0, 5'd2, 5'd1, 3'b001, 5'd4, 7'b1100011});
    prog.push_back({12'd8, 5'd1, 3'b010, 5'd5, 7'b0000011});
    prog.push_back(i_type_word(12'd3, 5'd0, 5'd2));
    while (prog.size() < num_total) begin
      prog.push_back(random_inst());
    end
  endtask

  // ------------------------------------------------------------
  // Clock, timeout and main sequence
  // ------------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the DUT stopped delivering results", cycle_limit);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    rst        = 1'b1;
    in_val     = 1'b0;
    in_inst    = '0;
    in_pc      = '0;
    in_seq_num = '0;
    out_rdy    = 1'b0;
    lfsr_state = 32'h1739;
    idx        = 0;
    hold       = 1'b0;
    tb_errors  = 0;
    build_program();
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;

    // Feed the program, valid held until taken
    while (idx < num_total) begin
      @(posedge clk);
      #1;
      out_rdy = (lfsr_bits(2) != 0);
      if (!hold) begin
        in_val = (lfsr_bits(2) != 0);
      end
      in_inst    = prog[idx];
      in_pc      = word_t'(32'h200 + 4 * idx);
      in_seq_num = seq_num_t'(idx);
      @(negedge clk);
      hold = in_val && !in_rdy;
      if (in_val && in_rdy) begin
        idx++;
      end
    end

    // Drain under back-pressure
    @(posedge clk);
    #1 in_val = 1'b0;
    while (outstanding != 0) begin
      out_rdy = (lfsr_bits(2) != 0);
      @(posedge clk);
      #1;
    end

    // Output open, nothing more may leave
    out_rdy = 1'b1;
    repeat (5) @(posedge clk);

    if (in_count != num_total) begin
      $display("Only %0d of %0d instructions were accepted", in_count, num_total);
      tb_errors++;
    end
    if (out_count != in_count) begin
      $display("%0d results left for %0d accepted instructions", out_count, in_count);
      tb_errors++;
    end
    $display("Summary: %0d in, %0d out, %0d mismatches, %0d other errors",
             in_count, out_count, error_count, tb_errors);
    if (error_count == 0 && tb_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== src/alu_pipe.sv ====
/*
  Single execute pipe. Computes add, addi or mul when the micro-op is
  accepted and holds the result until writeback takes it.
*/

`timescale 1ns/1ps

module alu_pipe import tinyrv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      x_val,
  output logic      x_rdy,
  input  word_t     x_pc,
  input  word_t     x_op1,
  input  word_t     x_op2,
  input  uop_t      x_uop,
  input  reg_addr_t x_waddr,
  input  logic      x_wen,
  input  seq_num_t  x_seq_num,
  output logic      w_val,
  input  logic      w_rdy,
  output word_t     w_pc,
  output word_t     w_wdata,
  output reg_addr_t w_waddr,
  output logic      w_wen,
  output seq_num_t  w_seq_num
);

  stage_state_t state;
  word_t        result;
  logic         x_xfer;
  logic         w_xfer;

  assign x_xfer = x_val & x_rdy;
  assign w_xfer = w_val & w_rdy;

  // ------------------------------------------------------------
  // Result select
  // ------------------------------------------------------------

  always_comb begin
    case (x_uop)
      uop_add, uop_addi: result = x_op1 + x_op2;
      // Low half of the product only
      uop_mul:           result = x_op1 * x_op2;
      default:           result = '0;
    endcase
  end

  // ------------------------------------------------------------
  // Stage register
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= empty;
    end else if (x_xfer) begin
      state <= full;
    end else if (w_xfer) begin
      state <= empty;
    end
  end

  always_ff @(posedge clk) begin
    if (x_xfer) begin
      w_pc      <= x_pc;
      w_wdata   <= result;
      w_waddr   <= x_waddr;
      w_wen     <= x_wen;
      w_seq_num <= x_seq_num;
    end
  end

  // Refill in the same cycle the result drains
  assign x_rdy = (state == empty) | w_rdy;
  assign w_val = (state == full);

endmodule

// ==== src/decode_issue_unit.sv ====
/*
  Decode and issue stage. Holds one fetched instruction, decodes it,
  reads operands and sends a micro-op once no source or destination waits.
*/

`timescale 1ns/1ps

module decode_issue_unit import tinyrv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      in_val,
  output logic      in_rdy,
  input  word_t     in_inst,
  input  word_t     in_pc,
  input  seq_num_t  in_seq_num,
  output logic      x_val,
  input  logic      x_rdy,
  output word_t     x_pc,
  output word_t     x_op1,
  output word_t     x_op2,
  output uop_t      x_uop,
  output reg_addr_t x_waddr,
  output logic      x_wen,
  output seq_num_t  x_seq_num,
  input  logic      c_val,
  input  reg_addr_t c_waddr,
  input  word_t     c_wdata
);

  // ------------------------------------------------------------
  // Fetch holding register
  // ------------------------------------------------------------

  stage_state_t state;
  word_t        inst_q;
  word_t        pc_q;
  seq_num_t     seq_q;
  logic         in_xfer;
  logic         x_xfer;

  assign in_xfer = in_val & in_rdy;
  assign x_xfer  = x_val & x_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= empty;
    end else if (in_xfer) begin
      state <= full;
    end else if (x_xfer) begin
      state <= empty;
    end
  end

  // Payload follows the handshake only
  always_ff @(posedge clk) begin
    if (in_xfer) begin
      inst_q <= in_inst;
      pc_q   <= in_pc;
      seq_q  <= in_seq_num;
    end
  end

  // ------------------------------------------------------------
  // Decode and operand read
  // ------------------------------------------------------------

  uop_t      dec_uop;
  reg_addr_t dec_raddr0;
  reg_addr_t dec_raddr1;
  reg_addr_t dec_waddr;
  logic      dec_wen;
  logic      dec_uses_rs2;
  word_t     dec_imm;
  word_t     rdata0;
  word_t     rdata1;
  logic      pend0;
  logic      pend1;
  logic      rd_pending;
  logic      stall;

  inst_decoder u_decoder (
    .inst     (inst_q),
    .uop      (dec_uop),
    .raddr0   (dec_raddr0),
    .raddr1   (dec_raddr1),
    .waddr    (dec_waddr),
    .wen      (dec_wen),
    .uses_rs2 (dec_uses_rs2),
    .imm      (dec_imm)
  );

  // rd goes pending on the issue edge
  regfile_scoreboard u_regfile (
    .clk           (clk),
    .rst           (rst),
    .raddr0        (dec_raddr0),
    .raddr1        (dec_raddr1),
    .rdata0        (rdata0),
    .rdata1        (rdata1),
    .pend0         (pend0),
    .pend1         (pend1),
    .check_addr    (dec_waddr),
    .check_pending (rd_pending),
    .set_val       (x_xfer & dec_wen),
    .set_addr      (dec_waddr),
    .c_val         (c_val),
    .c_waddr       (c_waddr),
    .c_wdata       (c_wdata)
  );

  // RAW on either source, WAW on rd
  assign stall = pend0 | (dec_uses_rs2 & pend1) | (dec_wen & rd_pending);

  // ------------------------------------------------------------
  // Issue
  // ------------------------------------------------------------

  assign x_val  = (state == full) & ~stall;
  assign in_rdy = (state == empty) | x_xfer;

  assign x_pc      = pc_q;
  assign x_op1     = rdata0;
  assign x_op2     = (dec_uop == uop_addi) ? dec_imm : rdata1;
  assign x_uop     = dec_uop;
  assign x_waddr   = dec_waddr;
  assign x_wen     = dec_wen;
  assign x_seq_num = seq_q;

endmodule

// ==== src/inst_decoder.sv ====
/*
  Combinational TinyRV1 decoder for the arithmetic subset.
  Maps an instruction word to a micro-op, register addresses and immediate.
*/

`timescale 1ns/1ps

module inst_decoder import tinyrv_pkg::*; (
  input  word_t     inst,
  output uop_t      uop,
  output reg_addr_t raddr0,
  output reg_addr_t raddr1,
  output reg_addr_t waddr,
  output logic      wen,
  output logic      uses_rs2,
  output word_t     imm
);

  // ------------------------------------------------------------
  // Instruction fields
  // ------------------------------------------------------------

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd;
  reg_addr_t  rs1;
  reg_addr_t  rs2;

  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  // I-type immediate, sign extended
  assign imm = {{20{inst[31]}}, inst[31:20]};

  // ------------------------------------------------------------
  // Micro-op selection
  // ------------------------------------------------------------

  always_comb begin
    // Unknown encodings fall out as nop with no sources
    uop      = uop_nop;
    raddr0   = '0;
    raddr1   = '0;
    uses_rs2 = 1'b0;

    if (opcode == opcode_op && funct3 == funct3_add) begin
      if (funct7 == funct7_add) begin
        uop = uop_add;
      end else if (funct7 == funct7_mul) begin
        uop = uop_mul;
      end
    end else if (opcode == opcode_op_imm && funct3 == funct3_add) begin
      uop = uop_addi;
    end

    // Source registers only for real ops
    if (uop != uop_nop) begin
      raddr0 = rs1;
    end
    if (uop == uop_add || uop == uop_mul) begin
      raddr1   = rs2;
      uses_rs2 = 1'b1;
    end
  end

  // Writes to x0 are dropped here
  assign waddr = rd;
  assign wen   = (uop != uop_nop) && (rd != '0);

endmodule

// ==== src/regfile_scoreboard.sv ====
/*
  32 x 32 register file with one pending bit per register.
  Issue reads operands and sets pending, writeback completes and clears it.
*/

`timescale 1ns/1ps

module regfile_scoreboard import tinyrv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t raddr0,
  input  reg_addr_t raddr1,
  output word_t     rdata0,
  output word_t     rdata1,
  output logic      pend0,
  output logic      pend1,
  input  reg_addr_t check_addr,
  output logic      check_pending,
  input  logic      set_val,
  input  reg_addr_t set_addr,
  input  logic      c_val,
  input  reg_addr_t c_waddr,
  input  word_t     c_wdata
);

  word_t               regs [num_regs];
  logic [num_regs-1:0] pending;

  // ------------------------------------------------------------
  // Write and scoreboard update
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
      pending <= '0;
    end else begin
      // Completion lands first
      if (c_val && c_waddr != '0) begin
        regs[c_waddr]    <= c_wdata;
        pending[c_waddr] <= 1'b0;
      end
      // New issue to the same register overrides the clear
      if (set_val && set_addr != '0) begin
        pending[set_addr] <= 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Combinational reads, no bypass
  // ------------------------------------------------------------

  // x0 reads zero and is never pending
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

  assign pend0         = pending[raddr0];
  assign pend1         = pending[raddr1];
  assign check_pending = pending[check_addr];

endmodule

// ==== src/tinyrv_issue_top.sv ====
/*
  Top of the issue slice. Chains decode/issue, execute and writeback,
  with the completion path fed back into the issue register file.
*/

`timescale 1ns/1ps

module tinyrv_issue_top import tinyrv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      in_val,
  output logic      in_rdy,
  input  word_t     in_inst,
  input  word_t     in_pc,
  input  seq_num_t  in_seq_num,
  output logic      out_val,
  input  logic      out_rdy,
  output word_t     out_pc,
  output seq_num_t  out_seq_num,
  output reg_addr_t out_waddr,
  output logic      out_wen,
  output word_t     out_wdata
);

  // ------------------------------------------------------------
  // Issue to execute
  // ------------------------------------------------------------

  logic      x_val;
  logic      x_rdy;
  word_t     x_pc;
  word_t     x_op1;
  word_t     x_op2;
  uop_t      x_uop;
  reg_addr_t x_waddr;
  logic      x_wen;
  seq_num_t  x_seq_num;

  // ------------------------------------------------------------
  // Execute to writeback, and completion back to issue
  // ------------------------------------------------------------

  logic      w_val;
  logic      w_rdy;
  word_t     w_pc;
  word_t     w_wdata;
  reg_addr_t w_waddr;
  logic      w_wen;
  seq_num_t  w_seq_num;
  logic      c_val;
  reg_addr_t c_waddr;
  word_t     c_wdata;

  decode_issue_unit u_issue (
    .clk        (clk),
    .rst        (rst),
    .in_val     (in_val),
    .in_rdy     (in_rdy),
    .in_inst    (in_inst),
    .in_pc      (in_pc),
    .in_seq_num (in_seq_num),
    .x_val      (x_val),
    .x_rdy      (x_rdy),
    .x_pc       (x_pc),
    .x_op1      (x_op1),
    .x_op2      (x_op2),
    .x_uop      (x_uop),
    .x_waddr    (x_waddr),
    .x_wen      (x_wen),
    .x_seq_num  (x_seq_num),
    .c_val      (c_val),
    .c_waddr    (c_waddr),
    .c_wdata    (c_wdata)
  );

  alu_pipe u_alu (
    .clk       (clk),
    .rst       (rst),
    .x_val     (x_val),
    .x_rdy     (x_rdy),
    .x_pc      (x_pc),
    .x_op1     (x_op1),
    .x_op2     (x_op2),
    .x_uop     (x_uop),
    .x_waddr   (x_waddr),
    .x_wen     (x_wen),
    .x_seq_num (x_seq_num),
    .w_val     (w_val),
    .w_rdy     (w_rdy),
    .w_pc      (w_pc),
    .w_wdata   (w_wdata),
    .w_waddr   (w_waddr),
    .w_wen     (w_wen),
    .w_seq_num (w_seq_num)
  );

  writeback_unit u_wb (
    .clk         (clk),
    .rst         (rst),
    .w_val       (w_val),
    .w_rdy       (w_rdy),
    .w_pc        (w_pc),
    .w_wdata     (w_wdata),
    .w_waddr     (w_waddr),
    .w_wen       (w_wen),
    .w_seq_num   (w_seq_num),
    .out_val     (out_val),
    .out_rdy     (out_rdy),
    .out_pc      (out_pc),
    .out_seq_num (out_seq_num),
    .out_waddr   (out_waddr),
    .out_wen     (out_wen),
    .out_wdata   (out_wdata),
    .c_val       (c_val),
    .c_waddr     (c_waddr),
    .c_wdata     (c_wdata)
  );

endmodule

// ==== src/tinyrv_pkg.sv ====
/*
  Shared types and constants for the TinyRV1 issue slice.
  Every stage imports this package for widths, micro-ops and stage state.
*/

package tinyrv_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------

  // Architectural register count
  localparam int num_regs = 32;

  // Tag width carried from fetch to writeback
  localparam int seq_num_bits = 8;

  // Data, instruction and pc words
  typedef logic [31:0] word_t;

  // Register index
  typedef logic [4:0] reg_addr_t;

  // Program order tag
  typedef logic [seq_num_bits-1:0] seq_num_t;

  // ------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------

  // RISC-V major opcodes used by TinyRV1 arithmetic
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;

  // funct3 shared by add, addi and mul
  localparam logic [2:0] funct3_add = 3'b000;

  // funct7 separates add from mul
  localparam logic [6:0] funct7_add = 7'b0000000;
  localparam logic [6:0] funct7_mul = 7'b0000001;

  // ------------------------------------------------------------
  // Micro-ops and stage state
  // ------------------------------------------------------------

  // What the execute pipe does with op1 and op2
  typedef enum logic [1:0] {
    uop_nop,
    uop_add,
    uop_addi,
    uop_mul
  } uop_t;

  // One-entry stage register, either holding an item or not
  typedef enum logic {
    empty,
    full
  } stage_state_t;

endpackage

// ==== src/writeback_unit.sv ====
/*
  Writeback stage. Presents one result on the output port and, when it
  leaves with a write, returns it to the register file as a completion.
*/

`timescale 1ns/1ps

module writeback_unit import tinyrv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      w_val,
  output logic      w_rdy,
  input  word_t     w_pc,
  input  word_t     w_wdata,
  input  reg_addr_t w_waddr,
  input  logic      w_wen,
  input  seq_num_t  w_seq_num,
  output logic      out_val,
  input  logic      out_rdy,
  output word_t     out_pc,
  output seq_num_t  out_seq_num,
  output reg_addr_t out_waddr,
  output logic      out_wen,
  output word_t     out_wdata,
  output logic      c_val,
  output reg_addr_t c_waddr,
  output word_t     c_wdata
);

  stage_state_t state;
  logic         w_xfer;
  logic         out_xfer;

  assign w_xfer   = w_val & w_rdy;
  assign out_xfer = out_val & out_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= empty;
    end else if (w_xfer) begin
      state <= full;
    end else if (out_xfer) begin
      state <= empty;
    end
  end

  always_ff @(posedge clk) begin
    if (w_xfer) begin
      out_pc      <= w_pc;
      out_seq_num <= w_seq_num;
      out_waddr   <= w_waddr;
      out_wen     <= w_wen;
      out_wdata   <= w_wdata;
    end
  end

  assign w_rdy   = (state == empty) | out_rdy;
  assign out_val = (state == full);

  // Completion fires on the output edge, writes only
  assign c_val   = out_xfer & out_wen;
  assign c_waddr = out_waddr;
  assign c_wdata = out_wdata;

endmodule

// ==== verilog.f ====
src/tinyrv_pkg.sv
src/inst_decoder.sv
src/regfile_scoreboard.sv
src/decode_issue_unit.sv
src/alu_pipe.sv
src/writeback_unit.sv
src/tinyrv_issue_top.sv
dv/tb_checker.sv
dv/tb_top.sv
